// File: compile.f
rtl/fibPkg.sv
rtl/fibCtrlIf.sv
rtl/fibSequencer.sv
rtl/regFile.sv
rtl/fibAlu.sv
rtl/fibDatapath.sv
rtl/resultPort.sv
rtl/fibCore.sv
verification/fibCore_assert.sv
verification/fibCoreTb.sv

// File: rtl/fibAlu.sv
`timescale 1ns/1ns

module fibAlu
    import fibPkg::*;
(
    input  logic [DataWidth-1:0] opA,
    input  logic [DataWidth-1:0] opB,
    input  aluOpT                op,
    output logic [DataWidth-1:0] result,
    output logic                 carry
);

    // full width sum, top bit is the carry out
    logic [DataWidth:0] sum;

    assign sum = {1'b0, opA} + {1'b0, opB};

    ////////////////////////////////////////////////////////////////////////////
    // function select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            // seed terms
            opLoadZero: begin
                result = '0;
                carry  = 1'b0;
            end
            opLoadOne: begin
                result = DataWidth'(1);
                carry  = 1'b0;
            end
            // normal step
            opAdd: begin
                result = sum[DataWidth-1:0];
                carry  = sum[DataWidth];
            end
            // unused code
            default: begin
                result = '0;
                carry  = 1'b0;
            end
        endcase
    end

endmodule

// File: rtl/fibCore.sv
`timescale 1ns/1ns

module fibCore
    import fibPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  logic [CountWidth-1:0] termCount,
    output logic                  busy,
    output logic                  termValid,
    output logic [CountWidth-1:0] termIndex,
    output logic [DataWidth-1:0]  termValue,
    output logic                  done,
    output logic                  overflow
);

    ////////////////////////////////////////////////////////////////////////////
    // internal links
    ////////////////////////////////////////////////////////////////////////////

    // sequencer to result port
    logic                 runStart;
    logic                 runDone;

    // datapath to result port
    logic                 termStrobe;
    logic [DataWidth-1:0] termData;
    logic                 termCarry;

    // selects, write enable and opcode
    fibCtrlIf ctrlBus (
        .clk (clk)
    );

    fibSequencer sequencer (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .termCount (termCount),
        .busy      (busy),
        .runStart  (runStart),
        .runDone   (runDone),
        .ctrl      (ctrlBus.sequencer)
    );

    fibDatapath datapath (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (ctrlBus.datapath),
        .termStrobe (termStrobe),
        .termData   (termData),
        .termCarry  (termCarry)
    );

    // registered term stream out
    resultPort results (
        .clk        (clk),
        .rstN       (rstN),
        .runStart   (runStart),
        .runDone    (runDone),
        .termStrobe (termStrobe),
        .termData   (termData),
        .termCarry  (termCarry),
        .termValid  (termValid),
        .termIndex  (termIndex),
        .termValue  (termValue),
        .done       (done),
        .overflow   (overflow)
    );

endmodule

// File: rtl/fibCtrlIf.sv
`timescale 1ns/1ns

interface fibCtrlIf
    import fibPkg::*;
(
    input logic clk
);

    // read selects for alu operands
    logic [RegAddrWidth-1:0] readAddrA;
    logic [RegAddrWidth-1:0] readAddrB;

    // write select and strobe
    logic [RegAddrWidth-1:0] writeAddr;
    logic                    writeEn;

    // alu function, valid with writeEn
    aluOpT                   aluOp;

    // sequencer drives everything
    modport sequencer (
        input  clk,
        output readAddrA,
        output readAddrB,
        output writeAddr,
        output writeEn,
        output aluOp
    );

    // datapath only listens
    modport datapath (
        input clk,
        input readAddrA,
        input readAddrB,
        input writeAddr,
        input writeEn,
        input aluOp
    );

endinterface

// File: rtl/fibDatapath.sv
`timescale 1ns/1ns

module fibDatapath
    import fibPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    fibCtrlIf.datapath           ctrl,
    output logic                 termStrobe,
    output logic [DataWidth-1:0] termData,
    output logic                 termCarry
);

    // operand buses
    logic [DataWidth-1:0] aBus;
    logic [DataWidth-1:0] bBus;

    // write bus, always the alu result
    logic [DataWidth-1:0] writeBus;
    logic                 aluCarry;

    regFile regs (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (ctrl.readAddrA),
        .readAddrB (ctrl.readAddrB),
        .writeAddr (ctrl.writeAddr),
        .writeEn   (ctrl.writeEn),
        .writeData (writeBus),
        .readDataA (aBus),
        .readDataB (bBus)
    );

    // opcode picks the write source, no buffers needed
    fibAlu alu (
        .opA    (aBus),
        .opB    (bBus),
        .op     (ctrl.aluOp),
        .result (writeBus),
        .carry  (aluCarry)
    );

    // write bus goes out as the term stream
    assign termStrobe = ctrl.writeEn;
    assign termData   = writeBus;
    assign termCarry  = aluCarry;

endmodule

// File: rtl/fibPkg.sv
package fibPkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    // one fibonacci term, same as the old 16 bit buses
    localparam int DataWidth = 16;

    // register file depth
    localparam int RegCount = 16;

    // register select width, log2 of RegCount
    localparam int RegAddrWidth = 4;

    // term count and term index, up to 31 terms
    localparam int CountWidth = 5;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    // alu functions kept from the old opcode set
    typedef enum logic [1:0] {
        opLoadZero,
        opLoadOne,
        opAdd
    } aluOpT;

    // sequencer states
    typedef enum logic [1:0] {
        stIdle,
        stLoadZero,
        stLoadOne,
        stAdd
    } seqStateT;

endpackage

// File: rtl/fibSequencer.sv
`timescale 1ns/1ns

module fibSequencer
    import fibPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  logic [CountWidth-1:0] termCount,
    output logic                  busy,
    output logic                  runStart,
    output logic                  runDone,
    fibCtrlIf.sequencer           ctrl
);

    seqStateT                state;
    seqStateT                nextState;

    // terms still to write, counting the current one
    logic [CountWidth-1:0]   remaining;

    // register being written this cycle, wraps at 16
    logic [RegAddrWidth-1:0] writePtr;

    logic                    accept;
    logic                    lastTerm;

    // only an idle sequencer takes a start, and a zero count is dropped
    assign accept   = (state == stIdle) && start && (termCount != '0);
    assign lastTerm = (remaining == CountWidth'(1));

    ////////////////////////////////////////////////////////////////////////////
    // state sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (accept) begin
                    nextState = stLoadZero;
                end
            end
            // count of one stops right here
            stLoadZero: nextState = lastTerm ? stIdle : stLoadOne;
            stLoadOne:  nextState = lastTerm ? stIdle : stAdd;
            stAdd:      nextState = lastTerm ? stIdle : stAdd;
            default:    nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= stIdle;
            remaining <= '0;
            writePtr  <= '0;
            busy      <= 1'b0;
            runStart  <= 1'b0;
            runDone   <= 1'b0;
        end else begin
            state    <= nextState;
            // pulses by default
            runStart <= 1'b0;
            runDone  <= 1'b0;
            if (accept) begin
                remaining <= termCount;
                writePtr  <= '0;
                busy      <= 1'b1;
                runStart  <= 1'b1;
            end else if (state != stIdle) begin
                // one register written per cycle
                writePtr <= writePtr + RegAddrWidth'(1);
                if (lastTerm) begin
                    busy    <= 1'b0;
                    runDone <= 1'b1;
                end else begin
                    remaining <= remaining - CountWidth'(1);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // control bus
    ////////////////////////////////////////////////////////////////////////////

    // term k comes from k-1 and k-2, wrap is free in 4 bits
    assign ctrl.writeAddr = writePtr;
    assign ctrl.readAddrA = writePtr - RegAddrWidth'(1);
    assign ctrl.readAddrB = writePtr - RegAddrWidth'(2);
    assign ctrl.writeEn   = (state != stIdle);

    always_comb begin
        case (state)
            stLoadZero: ctrl.aluOp = opLoadZero;
            stLoadOne:  ctrl.aluOp = opLoadOne;
            default:    ctrl.aluOp = opAdd;
        endcase
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ns

module regFile
    import fibPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [RegAddrWidth-1:0] readAddrA,
    input  logic [RegAddrWidth-1:0] readAddrB,
    input  logic [RegAddrWidth-1:0] writeAddr,
    input  logic                    writeEn,
    input  logic [DataWidth-1:0]    writeData,
    output logic [DataWidth-1:0]    readDataA,
    output logic [DataWidth-1:0]    readDataB
);

    // storage
    logic [DataWidth-1:0] regs [RegCount];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    // reset wipes every entry, like the old regReset line
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////////////////////

    // combinational, old contents during a write to the same entry
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

// File: rtl/resultPort.sv
`timescale 1ns/1ns

module resultPort
    import fibPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  runStart,
    input  logic                  runDone,
    input  logic                  termStrobe,
    input  logic [DataWidth-1:0]  termData,
    input  logic                  termCarry,
    output logic                  termValid,
    output logic [CountWidth-1:0] termIndex,
    output logic [DataWidth-1:0]  termValue,
    output logic                  done,
    output logic                  overflow
);

    // capture stage, lines up with the register write
    logic                  strobeQ;
    logic                  carryQ;
    logic [DataWidth-1:0]  dataQ;

    // index of the next term to go out
    logic [CountWidth-1:0] indexCnt;

    ////////////////////////////////////////////////////////////////////////////
    // capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            strobeQ <= 1'b0;
            carryQ  <= 1'b0;
        end else begin
            strobeQ <= termStrobe;
            carryQ  <= termStrobe & termCarry;
        end
    end

    always_ff @(posedge clk) begin
        if (termStrobe) begin
            dataQ <= termData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            termValid <= 1'b0;
            termIndex <= '0;
            indexCnt  <= '0;
            done      <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            termValid <= strobeQ;
            // runDone comes one cycle after the last write, so this meets the last term
            done      <= runDone;
            if (strobeQ) begin
                termIndex <= indexCnt;
            end
            // new run restarts the index
            if (runStart) begin
                indexCnt <= '0;
            end else if (strobeQ) begin
                indexCnt <= indexCnt + CountWidth'(1);
            end
            // sticky carry, acts as the flag register
            if (runStart) begin
                overflow <= 1'b0;
            end else if (carryQ) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobeQ) begin
            termValue <= dataQ;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns -j 0 \
    --top-module fibCoreTb -f compile.f -o fibSim

output=$(./obj_dir/fibSim 2>&1) || true
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
    exit 0
fi
exit 1

// File: verification/fibCoreTb.sv
`timescale 1ns/1ns

module fibCoreTb
    import fibPkg::*;
;

    logic                  clk;
    logic                  rstN;
    logic                  start;
    logic [CountWidth-1:0] termCount;
    logic                  busy;
    logic                  termValid;
    logic [CountWidth-1:0] termIndex;
    logic [DataWidth-1:0]  termValue;
    logic                  done;
    logic                  overflow;

    // expected terms and flag of the current run
    int                    expTerms [32];
    logic                  expOverflow;
    logic [31:0]           rngState;

    fibCore uut (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .termCount (termCount),
        .busy      (busy),
        .termValid (termValid),
        .termIndex (termIndex),
        .termValue (termValue),
        .done      (done),
        .overflow  (overflow)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // drive and sample point 1 ns past the edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            failRun($sformatf("** Error %s: %s expected %0d, actual %0d",
                              testName, what, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // fibonacci mod 2^16 and a flag set by any carry out of an add
    task automatic computeModel(input int count);
        logic [16:0] sum;
        expOverflow = 1'b0;
        for (int k = 0; k < count; k++) begin
            if (k < 2) begin
                expTerms[k] = k;
            end else begin
                sum = 17'(expTerms[k-1]) + 17'(expTerms[k-2]);
                expTerms[k] = int'(sum[15:0]);
                expOverflow = expOverflow | sum[16];
            end
        end
    endtask

    // one cycle start pulse that returns just after the start edge
    task automatic startRun(input int count);
        termCount = CountWidth'(count);
        start     = 1'b1;
        stepCycle();
        start     = 1'b0;
    endtask

    task automatic waitTermValid(input string testName);
        int cycles;
        cycles = 0;
        while (!termValid && cycles < 40) begin
            stepCycle();
            cycles++;
        end
        if (!termValid) begin
            failRun($sformatf("%s: no termValid within 40 cycles", testName));
        end
    endtask

    // nothing may come out for a while
    task automatic expectQuiet(input string testName, input int cycles);
        repeat (cycles) begin
            checkValue(testName, "termValid", 0, 32'(termValid));
            checkValue(testName, "done", 0, 32'(done));
            checkValue(testName, "busy", 0, 32'(busy));
            stepCycle();
        end
    endtask

    // whole term stream of one run against the model
    task automatic checkRun(input string testName, input int count);
        computeModel(count);
        waitTermValid(testName);
        for (int i = 0; i < count; i++) begin
            checkValue(testName, "termValid", 1, 32'(termValid));
            checkValue(testName, "termIndex", i, 32'(termIndex));
            checkValue(testName, "termValue", expTerms[i], 32'(termValue));
            checkValue(testName, "done", 32'(i == count - 1), 32'(done));
            // busy drops at the edge that writes the last term
            checkValue(testName, "busy", 32'(i < count - 2), 32'(busy));
            // cleared by the start before any add
            if (i == 0) begin
                checkValue(testName, "overflow at first term", 0, 32'(overflow));
            end
            if (i == count - 1) begin
                checkValue(testName, "overflow at done", 32'(expOverflow), 32'(overflow));
            end
            stepCycle();
        end
        checkValue(testName, "termValid after run", 0, 32'(termValid));
        checkValue(testName, "busy after run", 0, 32'(busy));
        checkValue(testName, "overflow after run", 32'(expOverflow), 32'(overflow));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testReset();
        checkValue("testReset", "overflow", 0, 32'(overflow));
        expectQuiet("testReset", 3);
    endtask

    task automatic testSingleTerm();
        startRun(1);
        checkRun("testSingleTerm", 1);
        expectQuiet("testSingleTerm", 4);
    endtask

    task automatic testShortRun();
        startRun(12);
        checkValue("testShortRun", "busy after start", 1, 32'(busy));
        checkValue("testShortRun", "termValid right after start", 0, 32'(termValid));
        stepCycle();
        checkValue("testShortRun", "termValid one cycle after start", 0, 32'(termValid));
        stepCycle();
        // two cycles after the start edge
        checkValue("testShortRun", "termValid two cycles after start", 1, 32'(termValid));
        checkRun("testShortRun", 12);
    endtask

    task automatic testOverflow();
        startRun(31);
        checkRun("testOverflow", 31);
        checkValue("testOverflow", "overflow", 1, 32'(overflow));
    endtask

    task automatic testIgnoredStart();
        startRun(10);
        // second start lands mid run
        termCount = CountWidth'(5);
        start     = 1'b1;
        stepCycle();
        start     = 1'b0;
        checkRun("testIgnoredStart", 10);
        // zero count while idle
        termCount = '0;
        start     = 1'b1;
        stepCycle();
        start     = 1'b0;
        expectQuiet("testIgnoredStart", 8);
    endtask

    task automatic testRandomRuns();
        int count;
        repeat (8) begin
            rngState = xorshift32(rngState);
            count    = int'(rngState % 32'd31) + 1;
            startRun(count);
            checkRun("testRandomRuns", count);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rngState   = 32'd36794;
        rstN       = 1'b0;
        start      = 1'b0;
        termCount  = '0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        testReset();
        testSingleTerm();
        testShortRun();
        testOverflow();
        testIgnoredStart();
        testRandomRuns();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: verification/fibCore_assert.sv
`timescale 1ns/1ns

module fibCoreAssert (
    input logic clk,
    input logic rstN,
    input logic busy,
    input logic termValid,
    input logic done
);

    ////////////////////////////////////////////////////////////////////////////
    // output protocol
    ////////////////////////////////////////////////////////////////////////////

    // term is written while busy and shows up two edges later
    assert property (@(posedge clk) disable iff (!rstN) termValid |-> $past(busy, 2))
        else $error("termValid seen without busy two cycles before");

    // single cycle pulse
    assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
        else $error("done held longer than one cycle");

    // done marks the last term
    assert property (@(posedge clk) disable iff (!rstN) done |-> termValid)
        else $error("done without termValid");

    // quiet right after reset release
    assert property (@(posedge clk) $rose(rstN) |-> (!busy && !termValid))
        else $error("busy or termValid high right after reset");

endmodule

bind fibCore fibCoreAssert checks (
    .clk       (clk),
    .rstN      (rstN),
    .busy      (busy),
    .termValid (termValid),
    .done      (done)
);
